/* dcache_top.f */
rtl/dcache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/dcache_props.sv
verification/dcache_tb.sv

/* verification/dcache_tb.sv */
/*
 * dcache_tb: directed tests for the two-way L1 data cache, with a line memory
 * model that stalls at random and a shadow copy of every word
 */
`timescale 1ns/1ps

module dcache_tb;

    localparam int MAX_CYCLES = 5000;    // ~20 accesses of under 50 cycles each, plus stalls

    logic                                clk;
    logic                                reset;
    logic                                cpu_valid;
    dcache_pkg::cpu_req_t                cpu_req;
    logic                                cpu_ready;
    logic                                cpu_resp_valid;
    logic [dcache_pkg::WORD_W-1:0]       cpu_rdata;
    logic                                mem_req_valid;
    mem_bus_pkg::mem_req_t               mem_req;
    logic                                mem_req_ready;
    logic                                mem_resp_valid;
    logic [dcache_pkg::LINE_W-1:0]       mem_resp_data;

    logic [dcache_pkg::LINE_W-1:0]       line_store [logic [mem_bus_pkg::LINE_ADDR_W-1:0]];
    logic [dcache_pkg::WORD_W-1:0]       shadow [logic [dcache_pkg::ADDR_W-1:0]];
    mem_bus_pkg::mem_op_t                seen_op [$];        // transfers seen by the model
    logic [mem_bus_pkg::LINE_ADDR_W-1:0] seen_addr [$];
    logic [dcache_pkg::LINE_W-1:0]       seen_wdata [$];
    logic                                hold_ready_low;
    int                                  cycle_count = 0;

    dcache_top u_dcache_top (
        .clk            (clk),
        .reset          (reset),
        .cpu_valid      (cpu_valid),
        .cpu_req        (cpu_req),
        .cpu_ready      (cpu_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_rdata      (cpu_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // bound controller checks
    always @(negedge clk) begin
        if (u_dcache_top.u_ctrl.u_props.fail_count != 0) begin
            $display("a handshake assertion on the controller failed");
            $display("test failed");
            $fatal(1, "run stopped by an assertion failure");
        end
    end

    task automatic check_value(input string name, input logic [159:0] actual,
                               input logic [159:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %0h, expected %0h", name, actual, expected);
            $display("test failed");
            $fatal(1, "check on %s failed", name);
        end
    endtask

    function automatic logic [dcache_pkg::ADDR_W-1:0] make_addr(input logic [19:0] tag,
                                                                input logic [7:0] index,
                                                                input logic [1:0] offset);
        return {tag, index, offset};
    endfunction

    // first touch of a line gives it random words, in memory and in the shadow
    function automatic void touch_line(input logic [mem_bus_pkg::LINE_ADDR_W-1:0] la);
        logic [dcache_pkg::LINE_W-1:0] line;
        if (!line_store.exists(la)) begin
            for (int i = 0; i < 4; i++) begin
                line[i*32 +: 32]    = $urandom;
                shadow[{la, 2'(i)}] = line[i*32 +: 32];
            end
            line_store[la] = line;
        end
    endfunction

    function automatic logic [dcache_pkg::LINE_W-1:0] shadow_line(
        input logic [mem_bus_pkg::LINE_ADDR_W-1:0] la
    );
        return {shadow[{la, 2'd3}], shadow[{la, 2'd2}], shadow[{la, 2'd1}], shadow[{la, 2'd0}]};
    endfunction

    function automatic void clear_log();
        seen_op.delete();
        seen_addr.delete();
        seen_wdata.delete();
    endfunction

    // line memory: sees the transfer mid-cycle, answers 1..4 cycles later
    initial begin : line_memory
        logic [dcache_pkg::LINE_W-1:0] resp_line;
        int                            latency;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        forever begin
            @(negedge clk);
            if (mem_req_valid && mem_req_ready) begin
                seen_op.push_back(mem_req.op);
                seen_addr.push_back(mem_req.line_addr);
                seen_wdata.push_back(mem_req.wdata);
                if (mem_req.op == mem_bus_pkg::MEM_WRITE) begin
                    line_store[mem_req.line_addr] = mem_req.wdata;
                    resp_line = '0;                      // plain ack
                end else begin
                    touch_line(mem_req.line_addr);
                    resp_line = line_store[mem_req.line_addr];
                end
                latency = $urandom_range(4, 1);
                @(posedge clk);
                #1;
                mem_req_ready = 1'b0;
                repeat (latency) @(posedge clk);
                #1;
                mem_resp_valid = 1'b1;
                mem_resp_data  = resp_line;
                @(posedge clk);
                #1;
                mem_resp_valid = 1'b0;
            end else begin
                @(posedge clk);
                #1;
                mem_req_ready = hold_ready_low ? 1'b0 : ($urandom_range(3, 0) != 0);
            end
        end
    end

    // one CPU request, entered and left 1 ns after a rising edge
    task automatic cpu_access(input logic write, input logic [dcache_pkg::ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int cycles);
        cpu_valid     = 1'b1;
        cpu_req.addr  = addr;
        cpu_req.write = write;
        cpu_req.wdata = wdata;
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        @(posedge clk);                                  // accepted here
        #1;
        cpu_valid = 1'b0;
        cycles    = 1;
        @(negedge clk);
        while (!cpu_resp_valid) begin
            @(negedge clk);
            cycles++;
        end
        rdata = cpu_rdata;
        @(posedge clk);
        #1;
    endtask

    task automatic read_and_check(input logic [dcache_pkg::ADDR_W-1:0] addr, output int cycles);
        logic [31:0] rd;
        touch_line(addr[29:2]);
        cpu_access(1'b0, addr, '0, rd, cycles);
        check_value("cpu_rdata", rd, shadow[addr]);
    endtask

    task automatic write_word(input logic [dcache_pkg::ADDR_W-1:0] addr, input logic [31:0] data,
                              output int cycles);
        logic [31:0] rd;
        touch_line(addr[29:2]);
        shadow[addr] = data;
        cpu_access(1'b1, addr, data, rd, cycles);
    endtask

    task automatic test_reset_state();
        check_value("cpu_ready", cpu_ready, 1'b1);
        check_value("mem_req_valid", mem_req_valid, 1'b0);
        check_value("cpu_resp_valid", cpu_resp_valid, 1'b0);
    endtask

    task automatic test_first_read();
        logic [dcache_pkg::ADDR_W-1:0] addr;
        int                            cycles;
        addr = make_addr(20'h00012, 8'h05, 2'd0);
        clear_log();
        read_and_check(addr, cycles);
        check_value("memory transfer count", seen_op.size(), 1);
        check_value("mem_req.op", seen_op[0], mem_bus_pkg::MEM_READ);
        check_value("mem_req.line_addr", seen_addr[0], addr[29:2]);
    endtask

    task automatic test_same_line_hit();
        int cycles;
        clear_log();
        read_and_check(make_addr(20'h00012, 8'h05, 2'd2), cycles);
        check_value("hit latency", cycles, 1);
        check_value("memory transfer count", seen_op.size(), 0);
    endtask

    task automatic test_write_hit();
        logic [dcache_pkg::ADDR_W-1:0] addr;
        int                            cycles;
        addr = make_addr(20'h00012, 8'h05, 2'd3);
        clear_log();
        write_word(addr, 32'hcafe_0013, cycles);
        check_value("write hit latency", cycles, 1);
        read_and_check(addr, cycles);
        check_value("hit latency", cycles, 1);
        read_and_check(make_addr(20'h00012, 8'h05, 2'd0), cycles);  // neighbour untouched
        check_value("memory transfer count", seen_op.size(), 0);
    endtask

    task automatic test_eviction();
        logic [dcache_pkg::ADDR_W-1:0] a;
        logic [dcache_pkg::ADDR_W-1:0] b;
        logic [dcache_pkg::ADDR_W-1:0] c;
        int                            cycles;
        a = make_addr(20'h00100, 8'h40, 2'd1);
        b = make_addr(20'h00200, 8'h40, 2'd0);
        c = make_addr(20'h00300, 8'h40, 2'd2);
        read_and_check(a, cycles);
        read_and_check(b, cycles);
        write_word(a, 32'h5a5a_1234, cycles);
        clear_log();
        read_and_check(c, cycles);                       // LRU names B, which is clean
        check_value("memory transfer count", seen_op.size(), 1);
        check_value("mem_req.op", seen_op[0], mem_bus_pkg::MEM_READ);
        check_value("mem_req.line_addr", seen_addr[0], c[29:2]);
        clear_log();
        read_and_check(b, cycles);                       // now A goes, dirty
        check_value("memory transfer count", seen_op.size(), 2);
        check_value("mem_req.op", seen_op[0], mem_bus_pkg::MEM_WRITE);
        check_value("mem_req.line_addr", seen_addr[0], a[29:2]);
        check_value("written word", seen_wdata[0][32 +: 32], 32'h5a5a_1234);
        check_value("mem_req.wdata", seen_wdata[0], shadow_line(a[29:2]));
        check_value("mem_req.op", seen_op[1], mem_bus_pkg::MEM_READ);
        check_value("mem_req.line_addr", seen_addr[1], b[29:2]);
        read_and_check(a, cycles);                       // refetched from written-back line
    endtask

    task automatic test_backpressure();
        logic [dcache_pkg::ADDR_W-1:0] addr;
        logic [31:0]                   rd;
        int                            cycles;
        mem_bus_pkg::mem_req_t         held;
        addr = make_addr(20'h00444, 8'h80, 2'd3);
        touch_line(addr[29:2]);
        hold_ready_low = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        clear_log();
        fork
            cpu_access(1'b0, addr, '0, rd, cycles);
            begin
                @(negedge clk);
                while (!mem_req_valid) @(negedge clk);
                held = mem_req;
                repeat (20) begin
                    @(negedge clk);
                    check_value("mem_req_valid", mem_req_valid, 1'b1);
                    check_value("mem_req", mem_req, held);
                    check_value("cpu_ready", cpu_ready, 1'b0);
                end
                hold_ready_low = 1'b0;
            end
        join
        check_value("cpu_rdata", rd, shadow[addr]);
        check_value("memory transfer count", seen_op.size(), 1);
        check_value("mem_req.op", seen_op[0], mem_bus_pkg::MEM_READ);
        check_value("mem_req.line_addr", seen_addr[0], addr[29:2]);
    endtask

    initial begin
        void'($urandom(53));
        reset          = 1'b1;
        cpu_valid      = 1'b0;
        cpu_req        = '0;
        hold_ready_low = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_first_read();
        test_same_line_hit();
        test_write_hit();
        test_eviction();
        test_backpressure();
        if (u_dcache_top.u_ctrl.u_props.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "a handshake assertion on the controller failed");
        end
    end

endmodule

/* verification/dcache_props.sv */
/*
 * dcache_props: handshake checks on the cache controller, bound into dcache_ctrl
 */
`timescale 1ns/1ps

module dcache_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  cpu_ready,
    input logic                  cpu_resp_valid,
    input logic                  mem_req_valid,
    input logic                  mem_req_ready,
    input mem_bus_pkg::mem_req_t mem_req
);

    int fail_count = 0;                          // failed assertion attempts so far

    // request held while memory stalls
    property mem_req_held;
        @(posedge clk) disable iff (reset)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req));
    endproperty

    property resp_not_with_ready;
        @(posedge clk) disable iff (reset)
        !(cpu_resp_valid && cpu_ready);
    endproperty

    // quiet ports right after any reset cycle
    property quiet_after_reset;
        @(posedge clk)
        reset |=> (!mem_req_valid && !cpu_resp_valid);
    endproperty

    a_mem_req_held: assert property (mem_req_held)
        else begin
            fail_count++;
            $error("memory request changed or dropped while mem_req_ready was low");
        end

    a_resp_not_with_ready: assert property (resp_not_with_ready)
        else begin
            fail_count++;
            $error("cpu_resp_valid and cpu_ready were high together");
        end

    a_quiet_after_reset: assert property (quiet_after_reset)
        else begin
            fail_count++;
            $error("mem_req_valid or cpu_resp_valid high in the cycle after reset");
        end

endmodule

bind dcache_ctrl dcache_props u_props (
    .clk            (clk),
    .reset          (reset),
    .cpu_ready      (cpu_ready),
    .cpu_resp_valid (cpu_resp_valid),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req)
);

/* rtl/dcache_top.sv */
/*
 * dcache_top: two-way write-back L1 data cache, controller plus tag and data arrays
 */
`timescale 1ns/1ps

module dcache_top (
    input  logic                              clk,
    input  logic                              reset,
    // CPU port
    input  logic                              cpu_valid,
    input  dcache_pkg::cpu_req_t              cpu_req,
    output logic                              cpu_ready,
    output logic                              cpu_resp_valid,
    output logic [dcache_pkg::WORD_W-1:0]     cpu_rdata,
    // line memory port
    output logic                              mem_req_valid,
    output mem_bus_pkg::mem_req_t             mem_req,
    input  logic                              mem_req_ready,
    input  logic                              mem_resp_valid,
    input  logic [dcache_pkg::LINE_W-1:0]     mem_resp_data
);

    logic [dcache_pkg::INDEX_W-1:0]  rd_index;
    logic [dcache_pkg::TAG_W-1:0]    tag_rd  [dcache_pkg::WAYS];
    logic [dcache_pkg::WAYS-1:0]     valid_rd;
    logic [dcache_pkg::WAYS-1:0]     dirty_rd;
    logic                            lru_rd;
    logic [dcache_pkg::LINE_W-1:0]   line_rd [dcache_pkg::WAYS];

    logic                            wr_en;
    logic                            wr_way;
    logic [dcache_pkg::TAG_W-1:0]    wr_tag;
    logic                            wr_dirty;
    logic [dcache_pkg::LINE_W-1:0]   wr_line;
    logic                            lru_en;
    logic                            lru_way;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .cpu_valid      (cpu_valid),
        .cpu_req        (cpu_req),
        .cpu_ready      (cpu_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_rdata      (cpu_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .rd_index       (rd_index),
        .tag_rd         (tag_rd),
        .valid_rd       (valid_rd),
        .dirty_rd       (dirty_rd),
        .lru_rd         (lru_rd),
        .line_rd        (line_rd),
        .wr_en          (wr_en),
        .wr_way         (wr_way),
        .wr_tag         (wr_tag),
        .wr_dirty       (wr_dirty),
        .wr_line        (wr_line),
        .lru_en         (lru_en),
        .lru_way        (lru_way)
    );

    dcache_tag_array u_tags (
        .clk      (clk),
        .reset    (reset),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_way   (wr_way),
        .wr_tag   (wr_tag),
        .wr_dirty (wr_dirty),
        .lru_en   (lru_en),
        .lru_way  (lru_way),
        .tag_rd   (tag_rd),
        .valid_rd (valid_rd),
        .dirty_rd (dirty_rd),
        .lru_rd   (lru_rd)
    );

    dcache_data_array u_data (
        .clk      (clk),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_way   (wr_way),
        .wr_line  (wr_line),
        .line_rd  (line_rd)
    );

endmodule

/* rtl/dcache_ctrl.sv */
/*
 * dcache_ctrl: hit detection, victim choice and write-back / fill sequencing
 * for the two-way write-back L1 data cache
 */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                 clk,
    input  logic                                 reset,
    // CPU side
    input  logic                                 cpu_valid,
    input  dcache_pkg::cpu_req_t                 cpu_req,
    output logic                                 cpu_ready,
    output logic                                 cpu_resp_valid,
    output logic [dcache_pkg::WORD_W-1:0]        cpu_rdata,
    // memory side
    output logic                                 mem_req_valid,
    output mem_bus_pkg::mem_req_t                mem_req,
    input  logic                                 mem_req_ready,
    input  logic                                 mem_resp_valid,
    input  logic [dcache_pkg::LINE_W-1:0]        mem_resp_data,
    // array read side
    output logic [dcache_pkg::INDEX_W-1:0]       rd_index,
    input  logic [dcache_pkg::TAG_W-1:0]         tag_rd [dcache_pkg::WAYS],
    input  logic [dcache_pkg::WAYS-1:0]          valid_rd,
    input  logic [dcache_pkg::WAYS-1:0]          dirty_rd,
    input  logic                                 lru_rd,
    input  logic [dcache_pkg::LINE_W-1:0]        line_rd [dcache_pkg::WAYS],
    // shared array write port
    output logic                                 wr_en,
    output logic                                 wr_way,
    output logic [dcache_pkg::TAG_W-1:0]         wr_tag,
    output logic                                 wr_dirty,
    output logic [dcache_pkg::LINE_W-1:0]        wr_line,
    output logic                                 lru_en,
    output logic                                 lru_way
);

    dcache_pkg::ctrl_state_t                  state, next_state;
    dcache_pkg::cpu_req_t                     req_q;            // request being served

    logic [dcache_pkg::WAYS-1:0]              hit_vec;
    logic                                     hit;
    logic                                     hit_way;
    logic                                     victim_way_c;
    logic [dcache_pkg::LINE_W-1:0]            hit_line;
    logic [dcache_pkg::LINE_W-1:0]            base_line;

    logic                                     victim_way_q;
    logic [dcache_pkg::LINE_W-1:0]            victim_line_q;
    logic [mem_bus_pkg::LINE_ADDR_W-1:0]      victim_addr_q;
    logic [dcache_pkg::LINE_W-1:0]            fill_line_q;

    function automatic logic [dcache_pkg::WORD_W-1:0] word_sel(
        input logic [dcache_pkg::LINE_W-1:0]   line,
        input logic [dcache_pkg::OFFSET_W-1:0] off
    );
        return line[off*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
    endfunction

    function automatic logic [dcache_pkg::LINE_W-1:0] word_merge(
        input logic [dcache_pkg::LINE_W-1:0]   line,
        input logic [dcache_pkg::OFFSET_W-1:0] off,
        input logic [dcache_pkg::WORD_W-1:0]   data
    );
        logic [dcache_pkg::LINE_W-1:0] merged;
        merged = line;
        merged[off*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] = data;
        return merged;
    endfunction

    // tag compare, both ways in parallel
    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            hit_vec[w] = valid_rd[w] && (tag_rd[w] == req_q.addr.tag);
        end
    end

    assign hit      = |hit_vec;
    assign hit_way  = hit_vec[1];                          // at most one way matches
    assign hit_line = line_rd[hit_way];

    // invalid way first, way 0 before way 1, then the LRU bit
    assign victim_way_c = !valid_rd[0] ? 1'b0 :
                          !valid_rd[1] ? 1'b1 : lru_rd;

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::ST_IDLE:
                if (cpu_valid) next_state = dcache_pkg::ST_LOOKUP;
            dcache_pkg::ST_LOOKUP:
                if (hit)                            next_state = dcache_pkg::ST_IDLE;
                else if (valid_rd[victim_way_c] && dirty_rd[victim_way_c])
                                                    next_state = dcache_pkg::ST_WB_REQ;
                else                                next_state = dcache_pkg::ST_FILL_REQ;
            dcache_pkg::ST_WB_REQ:
                if (mem_req_ready) next_state = dcache_pkg::ST_WB_WAIT;
            dcache_pkg::ST_WB_WAIT:
                if (mem_resp_valid) next_state = dcache_pkg::ST_FILL_REQ;  // write ack
            dcache_pkg::ST_FILL_REQ:
                if (mem_req_ready) next_state = dcache_pkg::ST_FILL_WAIT;
            dcache_pkg::ST_FILL_WAIT:
                if (mem_resp_valid) next_state = dcache_pkg::ST_FILL_DONE;
            dcache_pkg::ST_FILL_DONE:
                next_state = dcache_pkg::ST_IDLE;
            default:
                next_state = dcache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcache_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_valid && cpu_ready) begin
            req_q <= cpu_req;
        end
        if (state == dcache_pkg::ST_LOOKUP) begin                  // victim snapshot
            victim_way_q   <= victim_way_c;
            victim_line_q  <= line_rd[victim_way_c];
            victim_addr_q  <= {tag_rd[victim_way_c], req_q.addr.index};
        end
        if (state == dcache_pkg::ST_FILL_WAIT && mem_resp_valid) begin
            fill_line_q <= mem_resp_data;
        end
    end

    // index comes straight from the bus while idle so the lookup sees data next cycle
    assign rd_index  = (state == dcache_pkg::ST_IDLE) ? cpu_req.addr.index : req_q.addr.index;
    assign cpu_ready = (state == dcache_pkg::ST_IDLE);

    assign cpu_resp_valid = (state == dcache_pkg::ST_LOOKUP && hit) ||
                            (state == dcache_pkg::ST_FILL_DONE);
    assign cpu_rdata      = (state == dcache_pkg::ST_FILL_DONE) ?
                            word_sel(fill_line_q, req_q.addr.offset) :
                            word_sel(hit_line, req_q.addr.offset);

    // memory request built from registered values only, so it holds under back-pressure
    assign mem_req_valid     = (state == dcache_pkg::ST_WB_REQ) ||
                               (state == dcache_pkg::ST_FILL_REQ);
    assign mem_req.op        = (state == dcache_pkg::ST_WB_REQ) ?
                               mem_bus_pkg::MEM_WRITE : mem_bus_pkg::MEM_READ;
    assign mem_req.line_addr = (state == dcache_pkg::ST_WB_REQ) ? victim_addr_q :
                               {req_q.addr.tag, req_q.addr.index};
    assign mem_req.wdata     = victim_line_q;

    // array writes: write hit in lookup, or the fill
    assign base_line = (state == dcache_pkg::ST_FILL_DONE) ? fill_line_q : hit_line;
    assign wr_en     = (state == dcache_pkg::ST_LOOKUP && hit && req_q.write) ||
                       (state == dcache_pkg::ST_FILL_DONE);
    assign wr_way    = (state == dcache_pkg::ST_FILL_DONE) ? victim_way_q : hit_way;
    assign wr_tag    = req_q.addr.tag;
    assign wr_dirty  = req_q.write;
    assign wr_line   = req_q.write ? word_merge(base_line, req_q.addr.offset, req_q.wdata)
                                   : base_line;

    // the way just used becomes MRU
    assign lru_en  = cpu_resp_valid;
    assign lru_way = ~wr_way;

endmodule

/* rtl/dcache_data_array.sv */
/*
 * dcache_data_array: line storage for both ways,
 * registered read and full-line write
 */
`timescale 1ns/1ps

module dcache_data_array (
    input  logic                              clk,
    input  logic [dcache_pkg::INDEX_W-1:0]    rd_index,
    input  logic                              wr_en,
    input  logic                              wr_way,
    input  logic [dcache_pkg::LINE_W-1:0]     wr_line,
    output logic [dcache_pkg::LINE_W-1:0]     line_rd [dcache_pkg::WAYS]
);

    // one memory per way, maps onto a RAM macro
    logic [dcache_pkg::LINE_W-1:0] line_mem [dcache_pkg::WAYS][dcache_pkg::SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[wr_way][rd_index] <= wr_line;           // whole line at once
        end
    end

    // both ways read every cycle, the controller picks
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            line_rd[w] <= line_mem[w][rd_index];
        end
    end

endmodule

/* rtl/dcache_tag_array.sv */
/*
 * dcache_tag_array: tags plus valid, dirty and LRU state for both ways,
 * registered read, one write port shared with the data array
 */
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [dcache_pkg::INDEX_W-1:0]    rd_index,
    input  logic                              wr_en,
    input  logic                              wr_way,
    input  logic [dcache_pkg::TAG_W-1:0]      wr_tag,
    input  logic                              wr_dirty,
    input  logic                              lru_en,
    input  logic                              lru_way,
    output logic [dcache_pkg::TAG_W-1:0]      tag_rd [dcache_pkg::WAYS],
    output logic [dcache_pkg::WAYS-1:0]       valid_rd,
    output logic [dcache_pkg::WAYS-1:0]       dirty_rd,
    output logic                              lru_rd
);

    logic [dcache_pkg::TAG_W-1:0] tag_mem  [dcache_pkg::WAYS][dcache_pkg::SETS];
    logic [dcache_pkg::SETS-1:0]  valid_q  [dcache_pkg::WAYS];
    logic [dcache_pkg::SETS-1:0]  dirty_q  [dcache_pkg::WAYS];
    logic [dcache_pkg::SETS-1:0]  lru_q;                       // way to evict next

    // tag storage, writes use the same index as the read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][rd_index] <= wr_tag;
        end
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            tag_rd[w] <= tag_mem[w][rd_index];
        end
    end

    // state bits in flops so reset can clear every set at once
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (wr_en) begin
                valid_q[wr_way][rd_index] <= 1'b1;           // every write fills the way
                dirty_q[wr_way][rd_index] <= wr_dirty;
            end
            if (lru_en) begin
                lru_q[rd_index] <= lru_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_rd <= '0;
            dirty_rd <= '0;
            lru_rd   <= 1'b0;
        end else begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                valid_rd[w] <= valid_q[w][rd_index];
                dirty_rd[w] <= dirty_q[w][rd_index];
            end
            lru_rd <= lru_q[rd_index];
        end
    end

endmodule

/* rtl/mem_bus_pkg.sv */
/*
 * mem_bus_pkg: opcode and request format of the line-wide port
 * between the L1 data cache and the next memory level
 */
package mem_bus_pkg;

    // line address is tag followed by index
    localparam int LINE_ADDR_W = dcache_pkg::TAG_W + dcache_pkg::INDEX_W;

    typedef enum logic {
        MEM_READ  = 1'b0,                     // line fill
        MEM_WRITE = 1'b1                      // victim write-back
    } mem_op_t;

    typedef struct packed {
        mem_op_t                       op;
        logic [LINE_ADDR_W-1:0]        line_addr;
        logic [dcache_pkg::LINE_W-1:0] wdata; // only meaningful for MEM_WRITE
    } mem_req_t;

endpackage

/* rtl/dcache_pkg.sv */
/*
 * dcache_pkg: geometry, address split and request types of the L1 data cache,
 * plus the controller state encoding
 */
package dcache_pkg;

    localparam int ADDR_W   = 30;             // word address
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 2;

    localparam int SETS  = 256;
    localparam int WAYS  = 2;

    localparam int WORD_W = 32;
    localparam int LINE_W = 128;              // four words per line

    // word address as seen by the cache
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } word_addr_t;

    typedef struct packed {
        word_addr_t          addr;
        logic                write;           // 1 = store
        logic [WORD_W-1:0]   wdata;
    } cpu_req_t;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_WB_REQ    = 3'd2,
        ST_WB_WAIT   = 3'd3,
        ST_FILL_REQ  = 3'd4,
        ST_FILL_WAIT = 3'd5,
        ST_FILL_DONE = 3'd6
    } ctrl_state_t;

endpackage
